// ==== tb.f ====
rtl/sched_pkg.sv
rtl/ready_table.sv
rtl/dispatch_queue.sv
rtl/issue_select.sv
rtl/dispatch_top.sv
dv/tb_dispatch.sv

// ==== dv/tb_dispatch.sv ====
// Testbench for the dispatch stage
// Random decode groups, writebacks and flushes run against a reference model
// Concurrent assertions check issue order, readiness and the decode ready level
module tb_dispatch;

	localparam int unsigned QUEUE_DEPTH = 8;

	logic                                                 clk;
	logic                                                 rst_n;
	logic                                                 flush_i;
	logic [sched_pkg::DECODE_WIDTH-1:0]                   dec_valid_i;
	sched_pkg::dq_entry_t [sched_pkg::DECODE_WIDTH-1:0]   dec_entry_i;
	logic                                                 dec_ready_o;
	sched_pkg::wb_t [sched_pkg::WB_WIDTH-1:0]             wb_i;
	logic [sched_pkg::DISPATCH_WIDTH-1:0]                 issue_valid_o;
	sched_pkg::dq_entry_t [sched_pkg::DISPATCH_WIDTH-1:0] issue_entry_o;

	// Reference model state
	sched_pkg::dq_entry_t              m_q[$];
	logic [sched_pkg::PHY_REG_NUM-1:0] busy_m;
	logic                              fresh;
	// Expectations for the current cycle rebuilt at each edge
	int                                                   exp_cnt;
	logic                                                 exp_ready;
	sched_pkg::dq_entry_t [sched_pkg::DISPATCH_WIDTH-1:0] exp_e;

	logic        draining;
	logic [7:0]  next_tag = 8'h00;
	logic [31:0] lcg_q = 32'h5a6;
	int          mismatch_cnt = 0;
	int          fail_cnt = 0;

	dispatch_top #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) dut_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.flush_i       (flush_i),
		.dec_valid_i   (dec_valid_i),
		.dec_entry_i   (dec_entry_i),
		.dec_ready_o   (dec_ready_o),
		.wb_i          (wb_i),
		.issue_valid_o (issue_valid_o),
		.issue_entry_o (issue_entry_o)
	);

	always #4 clk = ~clk;

	function automatic int unsigned next_rand();
		lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
		return {16'd0, lcg_q[31:16]};
	endfunction

	// ========================================
	// Reference model and stimulus
	// ========================================
	always @(posedge clk) begin : model_and_drive
		sched_pkg::dq_entry_t              e;
		logic [sched_pkg::PHY_REG_NUM-1:0] busy_nxt;
		int                                n;
		int                                r;
		if (!rst_n || flush_i) begin
			m_q.delete();
			busy_m = '0;
			fresh = 1'b1;
		end else begin
			// Issued lanes leave from the front
			for (int k = 0; k < sched_pkg::DISPATCH_WIDTH; k++)
				if (issue_valid_o[k] && m_q.size() > 0)
					void'(m_q.pop_front());
			// Waiting entries wake on any matching writeback
			for (int i = 0; i < m_q.size(); i++) begin
				e = m_q[i];
				for (int j = 0; j < sched_pkg::WB_WIDTH; j++) begin
					if (wb_i[j].valid && wb_i[j].pdest == e.src0)
						e.src0_ready = 1'b1;
					if (wb_i[j].valid && wb_i[j].pdest == e.src1)
						e.src1_ready = 1'b1;
				end
				m_q[i] = e;
			end
			busy_nxt = busy_m;
			for (int j = 0; j < sched_pkg::WB_WIDTH; j++)
				if (wb_i[j].valid)
					busy_nxt[wb_i[j].pdest] = 1'b0;
			// Ready bits of an accepted group come from busy, bypass, then older lanes
			if (dec_ready_o && dec_valid_i != '0) begin
				fresh = 1'b0;
				for (int k = 0; k < sched_pkg::DECODE_WIDTH; k++) begin
					if (dec_valid_i[k]) begin
						e = dec_entry_i[k];
						e.src0_ready = !busy_m[e.src0];
						e.src1_ready = !busy_m[e.src1];
						for (int j = 0; j < sched_pkg::WB_WIDTH; j++) begin
							if (wb_i[j].valid && wb_i[j].pdest == e.src0)
								e.src0_ready = 1'b1;
							if (wb_i[j].valid && wb_i[j].pdest == e.src1)
								e.src1_ready = 1'b1;
						end
						for (int j = 0; j < k; j++) begin
							if (dec_valid_i[j] && dec_entry_i[j].pdest == e.src0)
								e.src0_ready = 1'b0;
							if (dec_valid_i[j] && dec_entry_i[j].pdest == e.src1)
								e.src1_ready = 1'b0;
						end
						m_q.push_back(e);
						// Allocation wins over a same cycle writeback
						busy_nxt[e.pdest] = 1'b1;
					end
				end
			end
			busy_m = busy_nxt;
		end
		exp_cnt = m_q.size();
		exp_ready = (exp_cnt <= int'(QUEUE_DEPTH - sched_pkg::DECODE_WIDTH));
		for (int k = 0; k < sched_pkg::DISPATCH_WIDTH; k++)
			exp_e[k] = (k < exp_cnt) ? m_q[k] : '0;

		if (!rst_n) begin
			flush_i <= 1'b0;
			dec_valid_i <= '0;
			wb_i <= '0;
		end else begin
			flush_i <= !draining && (next_rand() % 64 == 0);
			// A refused group is held until it is taken
			if (dec_valid_i == '0 || dec_ready_o || flush_i) begin
				n = draining ? 0 : int'(next_rand() % (sched_pkg::DECODE_WIDTH + 1));
				for (int k = 0; k < sched_pkg::DECODE_WIDTH; k++) begin
					// Small register set so dependencies are frequent
					e.tag = next_tag + 8'(k);
					e.pdest = sched_pkg::preg_t'(next_rand() % 8);
					e.src0 = sched_pkg::preg_t'(next_rand() % 8);
					e.src1 = sched_pkg::preg_t'(next_rand() % 8);
					e.src0_ready = 1'(next_rand());
					e.src1_ready = 1'(next_rand());
					dec_entry_i[k] <= e;
					dec_valid_i[k] <= (k < n);
				end
				next_tag = next_tag + 8'(sched_pkg::DECODE_WIDTH);
			end
			wb_i <= '0;
			n = 0;
			if (!draining) begin
				for (int j = 0; j < sched_pkg::WB_WIDTH; j++) begin
					r = int'(next_rand() % 8);
					if (busy_m[r] && next_rand() % 2 == 1)
						wb_i[j] <= {1'b1, sched_pkg::preg_t'(r)};
				end
			end else begin
				// Final writebacks of every busy register
				for (r = 0; r < sched_pkg::PHY_REG_NUM; r++) begin
					if (busy_m[r] && n < sched_pkg::WB_WIDTH) begin
						wb_i[n] <= {1'b1, sched_pkg::preg_t'(r)};
						n++;
					end
				end
			end
		end
	end

	// ========================================
	// Checks
	// ========================================
	a_clear: assert property (@(posedge clk) disable iff (!rst_n)
		fresh |-> issue_valid_o == '0 && dec_ready_o)
		else begin
			mismatch_cnt++;
			$display("mismatch issue_valid_o/dec_ready_o after clear: got %h/%h expected 0/1",
				$sampled(issue_valid_o), $sampled(dec_ready_o));
		end

	a_dec_ready: assert property (@(posedge clk) disable iff (!rst_n)
		dec_ready_o == exp_ready)
		else begin
			mismatch_cnt++;
			$display("mismatch dec_ready_o: got %h expected %h",
				$sampled(dec_ready_o), $sampled(exp_ready));
		end

	for (genvar g = 0; g < sched_pkg::DISPATCH_WIDTH; g++) begin : lane_chk
		a_extra: assert property (@(posedge clk) disable iff (!rst_n)
			issue_valid_o[g] |-> exp_cnt > g)
			else begin
				fail_cnt++;
				$display("lane %0d issued an instruction the model does not hold", g);
			end
		a_tag: assert property (@(posedge clk) disable iff (!rst_n)
			issue_valid_o[g] && exp_cnt > g |-> issue_entry_o[g].tag == exp_e[g].tag)
			else begin
				mismatch_cnt++;
				$display("mismatch issue_entry_o[%0d].tag: got %h expected %h", g,
					$sampled(issue_entry_o[g].tag), $sampled(exp_e[g].tag));
			end
		// Register fields travel with the tag
		a_regs: assert property (@(posedge clk) disable iff (!rst_n)
			issue_valid_o[g] && exp_cnt > g |->
				issue_entry_o[g].pdest == exp_e[g].pdest &&
				issue_entry_o[g].src0 == exp_e[g].src0 &&
				issue_entry_o[g].src1 == exp_e[g].src1)
			else begin
				mismatch_cnt++;
				$display("mismatch issue_entry_o[%0d] pdest/src0/src1: got %h/%h/%h expected %h/%h/%h",
					g, $sampled(issue_entry_o[g].pdest), $sampled(issue_entry_o[g].src0),
					$sampled(issue_entry_o[g].src1), $sampled(exp_e[g].pdest),
					$sampled(exp_e[g].src0), $sampled(exp_e[g].src1));
			end
		a_src_ready: assert property (@(posedge clk) disable iff (!rst_n)
			issue_valid_o[g] && exp_cnt > g |-> exp_e[g].src0_ready && exp_e[g].src1_ready)
			else begin
				fail_cnt++;
				$display("lane %0d issued while a source register was still busy", g);
			end
		if (g > 0) begin : order_chk
			a_order: assert property (@(posedge clk) disable iff (!rst_n)
				issue_valid_o[g] |-> issue_valid_o[g-1])
				else begin
					fail_cnt++;
					$display("lane %0d issued without the lower lane", g);
				end
		end
	end

	// ========================================
	// Run control
	// ========================================
	initial begin : run
		logic drained;
		clk = 1'b0;
		rst_n = 1'b0;
		flush_i = 1'b0;
		dec_valid_i = '0;
		dec_entry_i = '0;
		wb_i = '0;
		draining = 1'b0;
		drained = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2000) @(posedge clk);
		draining <= 1'b1;
		// Queue must empty once every busy register is written back
		for (int t = 0; t < 500 && !drained; t++) begin
			@(negedge clk);
			drained = (exp_cnt == 0) && (busy_m == '0);
		end
		if (!drained) begin
			fail_cnt++;
			$display("queue failed to drain, %0d entries still waiting", exp_cnt);
		end
		$display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== rtl/dispatch_top.sv ====
// Dispatch stage top level
// Ready table in front of the dispatch queue, in-order selector behind it
// Sets the queue depth for the whole stage
module dispatch_top #(
	parameter int unsigned QUEUE_DEPTH = 8
) (
	input  logic                                                   clk,
	input  logic                                                   rst_n,
	input  logic                                                   flush_i,
	input  logic [sched_pkg::DECODE_WIDTH-1:0]                     dec_valid_i,
	input  sched_pkg::dq_entry_t [sched_pkg::DECODE_WIDTH-1:0]     dec_entry_i,
	output logic                                                   dec_ready_o,
	input  sched_pkg::wb_t [sched_pkg::WB_WIDTH-1:0]               wb_i,
	output logic [sched_pkg::DISPATCH_WIDTH-1:0]                   issue_valid_o,
	output sched_pkg::dq_entry_t [sched_pkg::DISPATCH_WIDTH-1:0]   issue_entry_o
);

	// Decoded lanes with ready bits filled in
	sched_pkg::dq_entry_t [sched_pkg::DECODE_WIDTH-1:0]   rt_entry;
	// Queue head toward the selector
	logic [sched_pkg::DISPATCH_WIDTH-1:0]                 head_valid;
	sched_pkg::dq_entry_t [sched_pkg::DISPATCH_WIDTH-1:0] head_entry;
	logic [sched_pkg::DISPATCH_WIDTH-1:0]                 take;

	ready_table u_ready_table (
		.clk          (clk),
		.rst_n        (rst_n),
		.flush_i      (flush_i),
		.dec_valid_i  (dec_valid_i),
		.dec_accept_i (dec_ready_o),
		.dec_entry_i  (dec_entry_i),
		.wb_i         (wb_i),
		.entry_o      (rt_entry)
	);

	dispatch_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_dispatch_queue (
		.clk           (clk),
		.rst_n         (rst_n),
		.flush_i       (flush_i),
		.write_valid_i (dec_valid_i),
		.write_data_i  (rt_entry),
		.write_ready_o (dec_ready_o),
		.read_valid_o  (head_valid),
		.read_data_o   (head_entry),
		.read_ready_i  (take),
		.wb_i          (wb_i)
	);

	issue_select u_issue_select (
		.head_valid_i  (head_valid),
		.head_entry_i  (head_entry),
		.take_o        (take),
		.issue_valid_o (issue_valid_o),
		.issue_entry_o (issue_entry_o)
	);

endmodule

// ==== rtl/issue_select.sv ====
// In-order issue selector over the queue head lanes
// Issues the longest run of ready entries starting at the oldest
// take_o pops the issued lanes from the queue in the same cycle
module issue_select (
	input  logic [sched_pkg::DISPATCH_WIDTH-1:0]                   head_valid_i,
	input  sched_pkg::dq_entry_t [sched_pkg::DISPATCH_WIDTH-1:0]   head_entry_i,
	output logic [sched_pkg::DISPATCH_WIDTH-1:0]                   take_o,
	output logic [sched_pkg::DISPATCH_WIDTH-1:0]                   issue_valid_o,
	output sched_pkg::dq_entry_t [sched_pkg::DISPATCH_WIDTH-1:0]   issue_entry_o
);

	// Both operands available per lane
	logic [sched_pkg::DISPATCH_WIDTH-1:0] lane_ready;
	// Issue decision chained from lane 0
	logic [sched_pkg::DISPATCH_WIDTH-1:0] issue;

	// ========================================
	// Readiness
	// ========================================
	always_comb begin
		for (int k = 0; k < sched_pkg::DISPATCH_WIDTH; k++) begin
			lane_ready[k] = head_valid_i[k]
				& head_entry_i[k].src0_ready
				& head_entry_i[k].src1_ready;
		end
	end

	// ========================================
	// Program order chain
	// ========================================
	always_comb begin
		// Oldest lane only needs itself
		issue[0] = lane_ready[0];
		// Younger lanes wait on every older lane
		for (int k = 1; k < sched_pkg::DISPATCH_WIDTH; k++) begin
			issue[k] = lane_ready[k] & issue[k-1];
		end
	end

	// No back-pressure on the issue ports
	assign take_o        = issue;
	assign issue_valid_o = issue;

	// Payload of non-issued lanes is held at zero
	always_comb begin
		for (int k = 0; k < sched_pkg::DISPATCH_WIDTH; k++) begin
			issue_entry_o[k] = issue[k] ? head_entry_i[k] : '0;
		end
	end

endmodule

// ==== rtl/dispatch_queue.sv ====
// Circular buffer of dispatch entries between rename and issue
// Writes up to DECODE_WIDTH lanes at the tail, shows DISPATCH_WIDTH from the head
// Stored entries wake up on matching writeback lanes
// QUEUE_DEPTH comes from the top level and must be a power of two
module dispatch_queue #(
	parameter int unsigned QUEUE_DEPTH = 8
) (
	input  logic                                                   clk,
	input  logic                                                   rst_n,
	input  logic                                                   flush_i,
	input  logic [sched_pkg::DECODE_WIDTH-1:0]                     write_valid_i,
	input  sched_pkg::dq_entry_t [sched_pkg::DECODE_WIDTH-1:0]     write_data_i,
	output logic                                                   write_ready_o,
	output logic [sched_pkg::DISPATCH_WIDTH-1:0]                   read_valid_o,
	output sched_pkg::dq_entry_t [sched_pkg::DISPATCH_WIDTH-1:0]   read_data_o,
	input  logic [sched_pkg::DISPATCH_WIDTH-1:0]                   read_ready_i,
	input  sched_pkg::wb_t [sched_pkg::WB_WIDTH-1:0]               wb_i
);

	localparam int unsigned PTR_W = $clog2(QUEUE_DEPTH);
	localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

	// Entry storage
	sched_pkg::dq_entry_t [QUEUE_DEPTH-1:0] queue_q;
	sched_pkg::dq_entry_t [QUEUE_DEPTH-1:0] queue_n;

	// Pointers and occupancy
	logic [PTR_W-1:0] head_q;
	logic [PTR_W-1:0] tail_q;
	logic [CNT_W-1:0] cnt_q;
	logic [CNT_W-1:0] push_cnt;
	logic [CNT_W-1:0] pop_cnt;

	logic [sched_pkg::DECODE_WIDTH-1:0][PTR_W-1:0]   wr_ptr;
	logic [sched_pkg::DISPATCH_WIDTH-1:0][PTR_W-1:0] rd_ptr;
	logic                                            rd_prefix;

	// ========================================
	// Head lanes and accept level
	// ========================================

	// Room for a full group
	assign write_ready_o = (cnt_q <= CNT_W'(QUEUE_DEPTH - sched_pkg::DECODE_WIDTH));

	always_comb begin
		for (int i = 0; i < sched_pkg::DISPATCH_WIDTH; i++) begin
			rd_ptr[i]       = head_q + PTR_W'(i);
			read_valid_o[i] = (cnt_q > CNT_W'(i));
			read_data_o[i]  = queue_q[rd_ptr[i]];
		end
	end

	// Lane counts for this edge
	always_comb begin
		push_cnt = write_ready_o ? CNT_W'($countones(write_valid_i)) : '0;
		pop_cnt  = CNT_W'($countones(read_ready_i & read_valid_o));
	end

	// ========================================
	// Storage update
	// ========================================
	always_comb begin
		queue_n = queue_q;
		// Wake every slot on every writeback lane
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			for (int j = 0; j < sched_pkg::WB_WIDTH; j++) begin
				if (wb_i[j].valid && queue_q[i].src0 == wb_i[j].pdest)
					queue_n[i].src0_ready = 1'b1;
				if (wb_i[j].valid && queue_q[i].src1 == wb_i[j].pdest)
					queue_n[i].src1_ready = 1'b1;
			end
		end
		// New lanes at consecutive tail slots
		// Write data already carries its own bypassed ready bits
		for (int k = 0; k < sched_pkg::DECODE_WIDTH; k++) begin
			wr_ptr[k] = tail_q + PTR_W'(k);
			if (write_ready_o && write_valid_i[k])
				queue_n[wr_ptr[k]] = write_data_i[k];
		end
	end

	always_ff @(posedge clk) begin
		queue_q <= queue_n;
	end

	// Pointer and count registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head_q <= '0;
			tail_q <= '0;
			cnt_q  <= '0;
		end else if (flush_i) begin
			head_q <= '0;
			tail_q <= '0;
			cnt_q  <= '0;
		end else begin
			head_q <= head_q + PTR_W'(pop_cnt);
			tail_q <= tail_q + PTR_W'(push_cnt);
			cnt_q  <= cnt_q + push_cnt - pop_cnt;
		end
	end

	// ========================================
	// Checks
	// ========================================

	// Read ready must be a prefix that stays inside the valid lanes
	always_comb begin
		rd_prefix = ((read_ready_i & ~read_valid_o) == '0);
		for (int i = 1; i < sched_pkg::DISPATCH_WIDTH; i++) begin
			if (read_ready_i[i] && !read_ready_i[i-1])
				rd_prefix = 1'b0;
		end
	end

	a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
		cnt_q <= CNT_W'(QUEUE_DEPTH))
		else $error("queue count above depth");

	a_rd_prefix: assert property (@(posedge clk) disable iff (!rst_n)
		|read_ready_i |-> rd_prefix)
		else $error("read ready is not a prefix of read valid");

endmodule

// ==== rtl/ready_table.sv ====
// Busy bits of the physical registers
// Fills the source ready bits of each decoded lane before the queue
// Accepted groups mark their destinations busy, writebacks clear them
module ready_table (
	input  logic                                                   clk,
	input  logic                                                   rst_n,
	input  logic                                                   flush_i,
	input  logic [sched_pkg::DECODE_WIDTH-1:0]                     dec_valid_i,
	input  logic                                                   dec_accept_i,
	input  sched_pkg::dq_entry_t [sched_pkg::DECODE_WIDTH-1:0]     dec_entry_i,
	input  sched_pkg::wb_t [sched_pkg::WB_WIDTH-1:0]               wb_i,
	output sched_pkg::dq_entry_t [sched_pkg::DECODE_WIDTH-1:0]     entry_o
);

	// One bit per register, set while a producer is in flight
	logic [sched_pkg::PHY_REG_NUM-1:0] busy_q;
	logic [sched_pkg::PHY_REG_NUM-1:0] busy_n;
	logic                              valid_prefix;

	// ========================================
	// Source ready lookup
	// ========================================
	always_comb begin
		for (int k = 0; k < sched_pkg::DECODE_WIDTH; k++) begin
			entry_o[k] = dec_entry_i[k];
			// Table lookup
			entry_o[k].src0_ready = ~busy_q[dec_entry_i[k].src0];
			entry_o[k].src1_ready = ~busy_q[dec_entry_i[k].src1];
			// Same cycle writeback bypass
			for (int j = 0; j < sched_pkg::WB_WIDTH; j++) begin
				if (wb_i[j].valid && wb_i[j].pdest == dec_entry_i[k].src0)
					entry_o[k].src0_ready = 1'b1;
				if (wb_i[j].valid && wb_i[j].pdest == dec_entry_i[k].src1)
					entry_o[k].src1_ready = 1'b1;
			end
			// Older lane in the group produces this source
			for (int j = 0; j < k; j++) begin
				if (dec_valid_i[j] && dec_entry_i[j].pdest == dec_entry_i[k].src0)
					entry_o[k].src0_ready = 1'b0;
				if (dec_valid_i[j] && dec_entry_i[j].pdest == dec_entry_i[k].src1)
					entry_o[k].src1_ready = 1'b0;
			end
		end
	end

	// ========================================
	// Busy bit update
	// ========================================
	always_comb begin
		busy_n = busy_q;
		// Writebacks first
		for (int j = 0; j < sched_pkg::WB_WIDTH; j++) begin
			if (wb_i[j].valid)
				busy_n[wb_i[j].pdest] = 1'b0;
		end
		// Allocation wins over a writeback to the same register
		for (int k = 0; k < sched_pkg::DECODE_WIDTH; k++) begin
			if (dec_accept_i && dec_valid_i[k])
				busy_n[dec_entry_i[k].pdest] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q <= '0;
		end else if (flush_i) begin
			busy_q <= '0;
		end else begin
			busy_q <= busy_n;
		end
	end

	// No hole below a valid lane
	always_comb begin
		valid_prefix = 1'b1;
		for (int k = 1; k < sched_pkg::DECODE_WIDTH; k++) begin
			if (dec_valid_i[k] && !dec_valid_i[k-1])
				valid_prefix = 1'b0;
		end
	end

	// Decode side must present lanes from lane 0 upward
	a_dec_prefix: assert property (@(posedge clk) disable iff (!rst_n)
		dec_accept_i && |dec_valid_i |-> valid_prefix)
		else $error("decode valid mask is not a prefix");

endmodule

// ==== rtl/sched_pkg.sv ====
// Shared widths and types for the dispatch stage
// Decode, writeback and issue lane counts live here
// Modules refer to every item through sched_pkg:: scoped names
package sched_pkg;

	// ========================================
	// Lane counts
	// ========================================

	// Instructions written into the queue per cycle
	localparam int unsigned DECODE_WIDTH = 2;

	// Issue ports fed from the queue head
	localparam int unsigned DISPATCH_WIDTH = 2;

	// Result buses that broadcast a finished register
	localparam int unsigned WB_WIDTH = 2;

	// ========================================
	// Register file and tag sizes
	// ========================================

	// Physical register count after renaming
	localparam int unsigned PHY_REG_NUM = 32;

	// Index width of one physical register
	localparam int unsigned PREG_W = $clog2(PHY_REG_NUM);

	// Instruction id carried for tracking
	localparam int unsigned TAG_W = 8;

	typedef logic [PREG_W-1:0] preg_t;

	// ========================================
	// Payload structs
	// ========================================

	// One renamed instruction waiting for issue
	// Ready bits are owned by the ready table and the queue wakeup
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		preg_t            pdest;
		preg_t            src0;
		preg_t            src1;
		logic             src0_ready;
		logic             src1_ready;
	} dq_entry_t;

	// One writeback lane
	// Valid only for the single cycle of the strobe
	typedef struct packed {
		logic  valid;
		preg_t pdest;
	} wb_t;

endpackage
